// File: source/idStage_macros.svh
`ifndef IDSTAGE_MACROS_SVH
`define IDSTAGE_MACROS_SVH

// Data path and register file
`define WORD_WIDTH         16
`define REG_ADDR_WIDTH     4
`define REG_T              4'd8
`define REG_NONE           4'd0
`define PC_UNIT            16'd1

// Major opcodes, instruction bits 15:11
`define OP_NOP             5'b00001
`define OP_B               5'b00010
`define OP_BEQZ            5'b00100
`define OP_BNEZ            5'b00101
`define OP_ADDIU3          5'b01000
`define OP_ADDIU           5'b01001
`define OP_SLTI            5'b01010
`define OP_BTEQZ_GROUP     5'b01100
`define OP_LI              5'b01101
`define OP_CMPI            5'b01110
`define OP_LW              5'b10011
`define OP_SW              5'b11011
`define OP_TRINARY         5'b11100
`define OP_LOGIC_JUMP      5'b11101

// Function codes
// Bits 10:8
`define FUNCT_BTEQZ        3'b000
// Bits 1:0
`define FUNCT_ADDU         2'b01
`define FUNCT_SUBU         2'b11
// Bits 4:0
`define FUNCT_AND          5'b01100
`define FUNCT_OR           5'b01101
`define FUNCT_CMP          5'b01010
// Bits 7:0
`define FUNCT_JR           8'b00000000

// ALU operations sent to execute
`define ALU_OP_WIDTH       4
`define ALU_NOP            4'd0
`define ALU_ADD            4'd1
`define ALU_SUB            4'd2
`define ALU_AND            4'd3
`define ALU_OR             4'd4
`define ALU_SLT            4'd5
`define ALU_CMP            4'd6
`define ALU_LW             4'd7
`define ALU_SW             4'd8

// Branch kinds from decode to branch unit
`define BRANCH_KIND_WIDTH  3
`define BR_NONE            3'd0
`define BR_ALWAYS          3'd1
`define BR_IF_ZERO         3'd2
`define BR_IF_NONZERO      3'd3
`define BR_REGISTER        3'd4

`endif

// File: source/idPkg.sv
package idPkg;

  // One instruction word, three field layouts
  typedef union packed {
    // Register-register: ADDU, SUBU, AND, OR, CMP, JR
    struct packed {
      logic [4:0] opcode;
      logic [2:0] rx;
      logic [2:0] ry;
      logic [2:0] rz;
      logic [1:0] funct2;
    } rrr;
    // Register plus 8-bit immediate
    struct packed {
      logic [4:0] opcode;
      logic [2:0] rx;
      logic [7:0] imm8;
    } ri8;
    // Unconditional branch offset
    struct packed {
      logic [4:0]  opcode;
      logic [10:0] imm11;
    } i11;
  } instWordT;

endpackage

// File: source/readPortIf.sv
`timescale 1ns/1ns
`include "idStage_macros.svh"

interface readPortIf;
  logic                       enable;
  logic [`REG_ADDR_WIDTH-1:0] addr;
  logic [`WORD_WIDTH-1:0]     data;
  logic                       stall;

  // Decoder picks the register and gets back the resolved value
  modport decode (output enable, output addr, input data);

  // Bypass network resolves the value and flags a load-use hazard
  modport forward (input enable, input addr, output data, output stall);

  modport branch (input data);

  // Top level export of the read request
  modport observe (input enable, input addr, input stall);
endinterface

// File: source/operandForward.sv
`timescale 1ns/1ns
`include "idStage_macros.svh"

module operandForward (
  input  logic                       rstN_i,
  readPortIf.forward                 port,
  input  logic [`WORD_WIDTH-1:0]     regFileData_i,
  input  logic                       exWriteEn_i,
  input  logic [`REG_ADDR_WIDTH-1:0] exWriteAddr_i,
  input  logic [`WORD_WIDTH-1:0]     exWriteData_i,
  input  logic [`ALU_OP_WIDTH-1:0]   exAluOp_i,
  input  logic                       memWriteEn_i,
  input  logic [`REG_ADDR_WIDTH-1:0] memWriteAddr_i,
  input  logic [`WORD_WIDTH-1:0]     memWriteData_i
);

  logic loadUse;
  logic exHit;
  logic memHit;

  // Load result is not ready until after memory, so wait a cycle
  assign loadUse = (exAluOp_i == `ALU_LW) && (exWriteAddr_i == port.addr);
  assign exHit   = exWriteEn_i && (exWriteAddr_i == port.addr);
  assign memHit  = memWriteEn_i && (memWriteAddr_i == port.addr);

  // Youngest producer wins
  always_comb begin
    port.stall = 1'b0;
    port.data  = '0;
    if (rstN_i && port.enable) begin
      if (loadUse) begin
        port.stall = 1'b1;
      end else if (exHit) begin
        port.data = exWriteData_i;
      end else if (memHit) begin
        port.data = memWriteData_i;
      end else begin
        port.data = regFileData_i;
      end
    end
  end

endmodule

// File: source/decodeControl.sv
`timescale 1ns/1ns
`include "idStage_macros.svh"

module decodeControl
  import idPkg::*;
(
  input  instWordT                      inst_i,
  readPortIf.decode                     port1,
  readPortIf.decode                     port2,
  output logic [`WORD_WIDTH-1:0]        operand1_o,
  output logic [`WORD_WIDTH-1:0]        operand2_o,
  output logic [`ALU_OP_WIDTH-1:0]      aluOp_o,
  output logic                          writeEn_o,
  output logic [`REG_ADDR_WIDTH-1:0]    writeAddr_o,
  output logic [`BRANCH_KIND_WIDTH-1:0] branchKind_o
);

  logic [4:0]                 opcode;
  logic [4:0]                 funct5;
  logic [`REG_ADDR_WIDTH-1:0] rx;
  logic [`REG_ADDR_WIDTH-1:0] ry;
  logic [`REG_ADDR_WIDTH-1:0] rz;
  logic [`WORD_WIDTH-1:0]     sgnImm4;
  logic [`WORD_WIDTH-1:0]     sgnImm5;
  logic [`WORD_WIDTH-1:0]     sgnImm8;
  logic [`WORD_WIDTH-1:0]     zeroImm8;
  logic                       isRegPair;
  logic                       isJr;

  assign opcode = inst_i.rrr.opcode;
  assign funct5 = {inst_i.rrr.rz, inst_i.rrr.funct2};

  // 3-bit fields address R0..R7 only
  assign rx = {1'b0, inst_i.rrr.rx};
  assign ry = {1'b0, inst_i.rrr.ry};
  assign rz = {1'b0, inst_i.rrr.rz};

  assign sgnImm4  = {{(`WORD_WIDTH-4){inst_i.ri8.imm8[3]}}, inst_i.ri8.imm8[3:0]};
  assign sgnImm5  = {{(`WORD_WIDTH-5){inst_i.ri8.imm8[4]}}, inst_i.ri8.imm8[4:0]};
  assign sgnImm8  = {{(`WORD_WIDTH-8){inst_i.ri8.imm8[7]}}, inst_i.ri8.imm8};
  assign zeroImm8 = {{(`WORD_WIDTH-8){1'b0}}, inst_i.ri8.imm8};

  // Two-source register ops share one read pattern
  assign isRegPair =
    ((opcode == `OP_TRINARY) &&
     ((inst_i.rrr.funct2 == `FUNCT_ADDU) || (inst_i.rrr.funct2 == `FUNCT_SUBU))) ||
    ((opcode == `OP_LOGIC_JUMP) &&
     ((funct5 == `FUNCT_AND) || (funct5 == `FUNCT_OR) || (funct5 == `FUNCT_CMP)));
  assign isJr = (opcode == `OP_LOGIC_JUMP) && (inst_i.ri8.imm8 == `FUNCT_JR);

  // Read ports depend on the instruction alone
  always_comb begin
    port1.enable = 1'b0;
    port1.addr   = '0;
    port2.enable = 1'b0;
    port2.addr   = '0;
    if (isRegPair || (opcode == `OP_SW)) begin
      port1.enable = 1'b1;
      port1.addr   = rx;
      port2.enable = 1'b1;
      port2.addr   = ry;
    end else if ((opcode == `OP_BTEQZ_GROUP) && (inst_i.rrr.rx == `FUNCT_BTEQZ)) begin
      port1.enable = 1'b1;
      port1.addr   = `REG_T;
    end else if (isJr || (opcode == `OP_BEQZ) || (opcode == `OP_BNEZ) ||
                 (opcode == `OP_ADDIU3) || (opcode == `OP_ADDIU) ||
                 (opcode == `OP_SLTI) || (opcode == `OP_CMPI) || (opcode == `OP_LW)) begin
      port1.enable = 1'b1;
      port1.addr   = rx;
    end
  end

  // NOP and unknown codes keep the defaults
  always_comb begin
    operand1_o   = '0;
    operand2_o   = '0;
    aluOp_o      = `ALU_NOP;
    writeEn_o    = 1'b0;
    writeAddr_o  = `REG_NONE;
    branchKind_o = `BR_NONE;
    if (isRegPair) begin
      operand1_o = port1.data;
      operand2_o = port2.data;
      writeEn_o  = 1'b1;
    end
    case (opcode)
      `OP_B:    branchKind_o = `BR_ALWAYS;
      `OP_BEQZ: branchKind_o = `BR_IF_ZERO;
      `OP_BNEZ: branchKind_o = `BR_IF_NONZERO;
      `OP_BTEQZ_GROUP: begin
        if (inst_i.rrr.rx == `FUNCT_BTEQZ) begin
          branchKind_o = `BR_IF_ZERO;
        end
      end
      `OP_ADDIU3: begin
        operand1_o  = port1.data;
        operand2_o  = sgnImm4;
        aluOp_o     = `ALU_ADD;
        writeEn_o   = 1'b1;
        writeAddr_o = ry;
      end
      `OP_ADDIU, `OP_SLTI, `OP_CMPI: begin
        operand1_o  = port1.data;
        operand2_o  = sgnImm8;
        writeEn_o   = 1'b1;
        aluOp_o     = (opcode == `OP_ADDIU) ? `ALU_ADD :
                      (opcode == `OP_SLTI) ? `ALU_SLT : `ALU_CMP;
        writeAddr_o = (opcode == `OP_ADDIU) ? rx : `REG_T;
      end
      `OP_LI: begin
        operand1_o  = zeroImm8;
        aluOp_o     = `ALU_OR;
        writeEn_o   = 1'b1;
        writeAddr_o = rx;
      end
      `OP_LW: begin
        operand1_o  = port1.data;
        operand2_o  = sgnImm5;
        aluOp_o     = `ALU_LW;
        writeEn_o   = 1'b1;
        writeAddr_o = ry;
      end
      // Store address formed here with the store data on operand 2
      `OP_SW: begin
        operand1_o = port1.data + sgnImm5;
        operand2_o = port2.data;
        aluOp_o    = `ALU_SW;
      end
      `OP_TRINARY: begin
        if (isRegPair) begin
          aluOp_o     = (inst_i.rrr.funct2 == `FUNCT_SUBU) ? `ALU_SUB : `ALU_ADD;
          writeAddr_o = rz;
        end
      end
      `OP_LOGIC_JUMP: begin
        case (funct5)
          `FUNCT_AND: begin
            aluOp_o     = `ALU_AND;
            writeAddr_o = rx;
          end
          `FUNCT_OR: begin
            aluOp_o     = `ALU_OR;
            writeAddr_o = rx;
          end
          `FUNCT_CMP: begin
            aluOp_o     = `ALU_CMP;
            writeAddr_o = `REG_T;
          end
          default: begin
            if (isJr) begin
              branchKind_o = `BR_REGISTER;
            end
          end
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

// File: source/branchResolve.sv
`timescale 1ns/1ns
`include "idStage_macros.svh"

module branchResolve
  import idPkg::*;
(
  input  logic                          rstN_i,
  input  instWordT                      inst_i,
  input  logic [`WORD_WIDTH-1:0]        instAddr_i,
  input  logic                          inDelaySlot_i,
  input  logic [`BRANCH_KIND_WIDTH-1:0] branchKind_i,
  readPortIf.branch                     reg1,
  output logic                          jump_o,
  output logic [`WORD_WIDTH-1:0]        jumpTarget_o
);

  logic [`WORD_WIDTH-1:0] sgnImm8;
  logic [`WORD_WIDTH-1:0] sgnImm11;
  logic                   isZero;
  logic                   taken;

  assign sgnImm8  = {{(`WORD_WIDTH-8){inst_i.ri8.imm8[7]}}, inst_i.ri8.imm8};
  assign sgnImm11 = {{(`WORD_WIDTH-11){inst_i.i11.imm11[10]}}, inst_i.i11.imm11};
  assign isZero   = (reg1.data == '0);

  // Offsets are relative to the delay slot
  always_comb begin
    taken        = 1'b0;
    jumpTarget_o = '0;
    case (branchKind_i)
      `BR_ALWAYS: begin
        taken        = 1'b1;
        jumpTarget_o = instAddr_i + sgnImm11 + `PC_UNIT;
      end
      `BR_IF_ZERO, `BR_IF_NONZERO: begin
        taken        = (branchKind_i == `BR_IF_ZERO) ? isZero : !isZero;
        jumpTarget_o = instAddr_i + sgnImm8 + `PC_UNIT;
      end
      `BR_REGISTER: begin
        taken        = 1'b1;
        jumpTarget_o = reg1.data;
      end
      default: begin
      end
    endcase
  end

  // A branch sitting in a delay slot never redirects the PC
  assign jump_o = rstN_i && taken && !inDelaySlot_i;

endmodule

// File: source/idStage.sv
`timescale 1ns/1ns
`include "idStage_macros.svh"

module idStage
  import idPkg::*;
(
  input  logic                       rstN_i,
  input  logic [`WORD_WIDTH-1:0]     instAddr_i,
  input  instWordT                   inst_i,
  input  logic [`WORD_WIDTH-1:0]     reg1Data_i,
  input  logic [`WORD_WIDTH-1:0]     reg2Data_i,
  input  logic                       inDelaySlot_i,
  input  logic                       exWriteEn_i,
  input  logic [`REG_ADDR_WIDTH-1:0] exWriteAddr_i,
  input  logic [`WORD_WIDTH-1:0]     exWriteData_i,
  input  logic [`ALU_OP_WIDTH-1:0]   exAluOp_i,
  input  logic                       memWriteEn_i,
  input  logic [`REG_ADDR_WIDTH-1:0] memWriteAddr_i,
  input  logic [`WORD_WIDTH-1:0]     memWriteData_i,
  output logic                       reg1Enable_o,
  output logic [`REG_ADDR_WIDTH-1:0] reg1Addr_o,
  output logic                       reg2Enable_o,
  output logic [`REG_ADDR_WIDTH-1:0] reg2Addr_o,
  output logic                       jump_o,
  output logic [`WORD_WIDTH-1:0]     jumpTarget_o,
  output logic [`WORD_WIDTH-1:0]     operand1_o,
  output logic [`WORD_WIDTH-1:0]     operand2_o,
  output logic [`ALU_OP_WIDTH-1:0]   aluOp_o,
  output logic                       writeEn_o,
  output logic [`REG_ADDR_WIDTH-1:0] writeAddr_o,
  output logic                       stall_o
);

  logic [`BRANCH_KIND_WIDTH-1:0] branchKind;

  readPortIf port1If ();
  readPortIf port2If ();

  decodeControl decode0 (
    .inst_i       (inst_i),
    .port1        (port1If.decode),
    .port2        (port2If.decode),
    .operand1_o   (operand1_o),
    .operand2_o   (operand2_o),
    .aluOp_o      (aluOp_o),
    .writeEn_o    (writeEn_o),
    .writeAddr_o  (writeAddr_o),
    .branchKind_o (branchKind)
  );

  operandForward fwd1 (
    .rstN_i         (rstN_i),
    .port           (port1If.forward),
    .regFileData_i  (reg1Data_i),
    .exWriteEn_i    (exWriteEn_i),
    .exWriteAddr_i  (exWriteAddr_i),
    .exWriteData_i  (exWriteData_i),
    .exAluOp_i      (exAluOp_i),
    .memWriteEn_i   (memWriteEn_i),
    .memWriteAddr_i (memWriteAddr_i),
    .memWriteData_i (memWriteData_i)
  );

  operandForward fwd2 (
    .rstN_i         (rstN_i),
    .port           (port2If.forward),
    .regFileData_i  (reg2Data_i),
    .exWriteEn_i    (exWriteEn_i),
    .exWriteAddr_i  (exWriteAddr_i),
    .exWriteData_i  (exWriteData_i),
    .exAluOp_i      (exAluOp_i),
    .memWriteEn_i   (memWriteEn_i),
    .memWriteAddr_i (memWriteAddr_i),
    .memWriteData_i (memWriteData_i)
  );

  // Only port 1 ever feeds a branch decision
  branchResolve branch0 (
    .rstN_i        (rstN_i),
    .inst_i        (inst_i),
    .instAddr_i    (instAddr_i),
    .inDelaySlot_i (inDelaySlot_i),
    .branchKind_i  (branchKind),
    .reg1          (port1If.branch),
    .jump_o        (jump_o),
    .jumpTarget_o  (jumpTarget_o)
  );

  // Read requests go out to the register file
  assign reg1Enable_o = port1If.enable;
  assign reg1Addr_o   = port1If.addr;
  assign reg2Enable_o = port2If.enable;
  assign reg2Addr_o   = port2If.addr;

  assign stall_o = port1If.stall | port2If.stall;

endmodule

// File: testbench/idStageTb.sv
`timescale 1ns/1ns
`include "idStage_macros.svh"

module idStageTb
  import idPkg::*;
();

  // Reset, one NOP, then 126 driven cycles and a final drain edge
  localparam int STIM_CYCLES = 131;
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;

  logic                       clk;
  logic                       rstN;
  logic [`WORD_WIDTH-1:0]     instAddr;
  instWordT                   inst;
  logic [`WORD_WIDTH-1:0]     reg1Data;
  logic [`WORD_WIDTH-1:0]     reg2Data;
  logic                       inDelaySlot;
  logic                       exWriteEn;
  logic [`REG_ADDR_WIDTH-1:0] exWriteAddr;
  logic [`WORD_WIDTH-1:0]     exWriteData;
  logic [`ALU_OP_WIDTH-1:0]   exAluOp;
  logic                       memWriteEn;
  logic [`REG_ADDR_WIDTH-1:0] memWriteAddr;
  logic [`WORD_WIDTH-1:0]     memWriteData;
  logic                       reg1Enable;
  logic [`REG_ADDR_WIDTH-1:0] reg1Addr;
  logic                       reg2Enable;
  logic [`REG_ADDR_WIDTH-1:0] reg2Addr;
  logic                       jump;
  logic [`WORD_WIDTH-1:0]     jumpTarget;
  logic [`WORD_WIDTH-1:0]     operand1;
  logic [`WORD_WIDTH-1:0]     operand2;
  logic [`ALU_OP_WIDTH-1:0]   aluOp;
  logic                       writeEn;
  logic [`REG_ADDR_WIDTH-1:0] writeAddr;
  logic                       stall;

  // Expected outputs
  logic                       expR1En;
  logic [`REG_ADDR_WIDTH-1:0] expR1Addr;
  logic                       expR2En;
  logic [`REG_ADDR_WIDTH-1:0] expR2Addr;
  logic                       expJump;
  logic                       expBranch;
  logic [`WORD_WIDTH-1:0]     expTarget;
  logic [`WORD_WIDTH-1:0]     expOp1;
  logic [`WORD_WIDTH-1:0]     expOp2;
  logic [`ALU_OP_WIDTH-1:0]   expAlu;
  logic                       expWe;
  logic [`REG_ADDR_WIDTH-1:0] expWa;
  logic                       expStall;

  integer seed = 9120;
  int     errors = 0;
  int     cycles = 0;

  idStage dut0 (
    .rstN_i         (rstN),
    .instAddr_i     (instAddr),
    .inst_i         (inst),
    .reg1Data_i     (reg1Data),
    .reg2Data_i     (reg2Data),
    .inDelaySlot_i  (inDelaySlot),
    .exWriteEn_i    (exWriteEn),
    .exWriteAddr_i  (exWriteAddr),
    .exWriteData_i  (exWriteData),
    .exAluOp_i      (exAluOp),
    .memWriteEn_i   (memWriteEn),
    .memWriteAddr_i (memWriteAddr),
    .memWriteData_i (memWriteData),
    .reg1Enable_o   (reg1Enable),
    .reg1Addr_o     (reg1Addr),
    .reg2Enable_o   (reg2Enable),
    .reg2Addr_o     (reg2Addr),
    .jump_o         (jump),
    .jumpTarget_o   (jumpTarget),
    .operand1_o     (operand1),
    .operand2_o     (operand2),
    .aluOp_o        (aluOp),
    .writeEn_o      (writeEn),
    .writeAddr_o    (writeAddr),
    .stall_o        (stall)
  );

  always #50 clk = ~clk;

  function automatic logic [`WORD_WIDTH-1:0] signExtend(input logic [`WORD_WIDTH-1:0] value,
                                                       input int width);
    logic [`WORD_WIDTH-1:0] result;
    result = value;
    for (int i = width; i < `WORD_WIDTH; i++) begin
      result[i] = value[width-1];
    end
    return result;
  endfunction

  function automatic logic loadUse(input logic [`REG_ADDR_WIDTH-1:0] addr);
    return rstN && (exAluOp == `ALU_LW) && (exWriteAddr == addr);
  endfunction

  // Value seen by an enabled read port: youngest producer first
  function automatic logic [`WORD_WIDTH-1:0] portData(input logic [`REG_ADDR_WIDTH-1:0] addr,
                                                     input logic [`WORD_WIDTH-1:0] regFile);
    logic [`WORD_WIDTH-1:0] value;
    if (!rstN || loadUse(addr)) begin
      value = '0;
    end else if (exWriteEn && (exWriteAddr == addr)) begin
      value = exWriteData;
    end else if (memWriteEn && (memWriteAddr == addr)) begin
      value = memWriteData;
    end else begin
      value = regFile;
    end
    return value;
  endfunction

  task automatic readPorts(input logic en1, input logic [`REG_ADDR_WIDTH-1:0] addr1,
                           input logic en2, input logic [`REG_ADDR_WIDTH-1:0] addr2);
    expR1En   = en1;
    expR1Addr = addr1;
    expR2En   = en2;
    expR2Addr = addr2;
  endtask

  task automatic setAlu(input logic [`WORD_WIDTH-1:0] op1, input logic [`WORD_WIDTH-1:0] op2,
                        input logic [`ALU_OP_WIDTH-1:0] alu, input logic we,
                        input logic [`REG_ADDR_WIDTH-1:0] wa);
    expOp1 = op1;
    expOp2 = op2;
    expAlu = alu;
    expWe  = we;
    expWa  = wa;
  endtask

  // Reference decode built from the instruction tables
  task automatic predict();
    logic [4:0]                 op;
    logic [4:0]                 funct5;
    logic [`REG_ADDR_WIDTH-1:0] rx;
    logic [`REG_ADDR_WIDTH-1:0] ry;
    logic [`WORD_WIDTH-1:0]     x;
    logic [`WORD_WIDTH-1:0]     y;
    logic [`WORD_WIDTH-1:0]     imm5;
    logic [`WORD_WIDTH-1:0]     imm8;
    logic [`WORD_WIDTH-1:0]     branchBase;
    op         = inst.rrr.opcode;
    funct5     = {inst.rrr.rz, inst.rrr.funct2};
    rx         = {1'b0, inst.rrr.rx};
    ry         = {1'b0, inst.rrr.ry};
    x          = portData(rx, reg1Data);
    y          = portData(ry, reg2Data);
    imm5       = signExtend({11'd0, inst.ri8.imm8[4:0]}, 5);
    imm8       = signExtend({8'd0, inst.ri8.imm8}, 8);
    branchBase = instAddr + imm8 + `PC_UNIT;
    readPorts(1'b0, 4'd0, 1'b0, 4'd0);
    setAlu('0, '0, `ALU_NOP, 1'b0, `REG_NONE);
    expJump   = 1'b0;
    expBranch = 1'b0;
    expTarget = '0;
    case (op)
      `OP_TRINARY: begin
        if ((inst.rrr.funct2 == `FUNCT_ADDU) || (inst.rrr.funct2 == `FUNCT_SUBU)) begin
          readPorts(1'b1, rx, 1'b1, ry);
          setAlu(x, y, (inst.rrr.funct2 == `FUNCT_SUBU) ? `ALU_SUB : `ALU_ADD, 1'b1,
                 {1'b0, inst.rrr.rz});
        end
      end
      `OP_LOGIC_JUMP: begin
        if (inst.ri8.imm8 == `FUNCT_JR) begin
          readPorts(1'b1, rx, 1'b0, 4'd0);
          expBranch = 1'b1;
          expJump   = 1'b1;
          expTarget = x;
        end else if (funct5 == `FUNCT_AND) begin
          readPorts(1'b1, rx, 1'b1, ry);
          setAlu(x, y, `ALU_AND, 1'b1, rx);
        end else if (funct5 == `FUNCT_OR) begin
          readPorts(1'b1, rx, 1'b1, ry);
          setAlu(x, y, `ALU_OR, 1'b1, rx);
        end else if (funct5 == `FUNCT_CMP) begin
          readPorts(1'b1, rx, 1'b1, ry);
          setAlu(x, y, `ALU_CMP, 1'b1, `REG_T);
        end
      end
      `OP_ADDIU: begin
        readPorts(1'b1, rx, 1'b0, 4'd0);
        setAlu(x, imm8, `ALU_ADD, 1'b1, rx);
      end
      `OP_ADDIU3: begin
        readPorts(1'b1, rx, 1'b0, 4'd0);
        setAlu(x, signExtend({12'd0, inst.ri8.imm8[3:0]}, 4), `ALU_ADD, 1'b1, ry);
      end
      `OP_SLTI: begin
        readPorts(1'b1, rx, 1'b0, 4'd0);
        setAlu(x, imm8, `ALU_SLT, 1'b1, `REG_T);
      end
      `OP_CMPI: begin
        readPorts(1'b1, rx, 1'b0, 4'd0);
        setAlu(x, imm8, `ALU_CMP, 1'b1, `REG_T);
      end
      `OP_LI: setAlu({8'd0, inst.ri8.imm8}, '0, `ALU_OR, 1'b1, rx);
      `OP_LW: begin
        readPorts(1'b1, rx, 1'b0, 4'd0);
        setAlu(x, imm5, `ALU_LW, 1'b1, ry);
      end
      `OP_SW: begin
        readPorts(1'b1, rx, 1'b1, ry);
        setAlu(x + imm5, y, `ALU_SW, 1'b0, `REG_NONE);
      end
      `OP_B: begin
        expBranch = 1'b1;
        expJump   = 1'b1;
        expTarget = instAddr + signExtend({5'd0, inst.i11.imm11}, 11) + `PC_UNIT;
      end
      `OP_BEQZ, `OP_BNEZ: begin
        readPorts(1'b1, rx, 1'b0, 4'd0);
        expBranch = 1'b1;
        expJump   = (op == `OP_BEQZ) ? (x == '0) : (x != '0);
        expTarget = branchBase;
      end
      `OP_BTEQZ_GROUP: begin
        if (inst.rrr.rx == `FUNCT_BTEQZ) begin
          readPorts(1'b1, `REG_T, 1'b0, 4'd0);
          expBranch = 1'b1;
          expJump   = (portData(`REG_T, reg1Data) == '0);
          expTarget = branchBase;
        end
      end
      default: begin
      end
    endcase
    expJump  = expJump && rstN && !inDelaySlot;
    expStall = (expR1En && loadUse(expR1Addr)) || (expR2En && loadUse(expR2Addr));
  endtask

  task automatic reportMismatch(input string what);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, what);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    predict();
    assert (reg1Enable == expR1En && reg1Addr == expR1Addr)
      else reportMismatch($sformatf("port 1 read %b/%0d, expected %b/%0d",
                                    reg1Enable, reg1Addr, expR1En, expR1Addr));
    assert (reg2Enable == expR2En && reg2Addr == expR2Addr)
      else reportMismatch($sformatf("port 2 read %b/%0d, expected %b/%0d",
                                    reg2Enable, reg2Addr, expR2En, expR2Addr));
    assert (operand1 == expOp1)
      else reportMismatch($sformatf("operand1 %h, expected %h", operand1, expOp1));
    assert (operand2 == expOp2)
      else reportMismatch($sformatf("operand2 %h, expected %h", operand2, expOp2));
    assert (aluOp == expAlu)
      else reportMismatch($sformatf("aluOp %0d, expected %0d", aluOp, expAlu));
    assert (writeEn == expWe && writeAddr == expWa)
      else reportMismatch($sformatf("write %b/%0d, expected %b/%0d",
                                    writeEn, writeAddr, expWe, expWa));
    assert (stall == expStall)
      else reportMismatch($sformatf("stall %b, expected %b", stall, expStall));
    assert (jump == expJump)
      else reportMismatch($sformatf("jump %b, expected %b", jump, expJump));
    if (expBranch) begin
      assert (jumpTarget == expTarget)
        else reportMismatch($sformatf("target %h, expected %h", jumpTarget, expTarget));
    end
  end

  initial begin : watchdog
    wait (cycles >= CYCLE_LIMIT);
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Regression failed");
    $finish;
  end

  function automatic logic [15:0] aluWord(input int kind, input logic [2:0] rx,
                                          input logic [2:0] ry, input logic [2:0] rz,
                                          input logic [7:0] imm);
    case (kind)
      0: return {`OP_TRINARY, rx, ry, rz, `FUNCT_ADDU};
      1: return {`OP_TRINARY, rx, ry, rz, `FUNCT_SUBU};
      2: return {`OP_LOGIC_JUMP, rx, ry, `FUNCT_AND};
      3: return {`OP_LOGIC_JUMP, rx, ry, `FUNCT_OR};
      4: return {`OP_LOGIC_JUMP, rx, ry, `FUNCT_CMP};
      5: return {`OP_ADDIU, rx, imm};
      6: return {`OP_ADDIU3, rx, ry, imm[4:0]};
      7: return {`OP_SLTI, rx, imm};
      8: return {`OP_CMPI, rx, imm};
      default: return {`OP_LI, rx, imm};
    endcase
  endfunction

  function automatic logic [15:0] branchWord(input int kind, input logic [2:0] rx,
                                             input logic [10:0] imm11);
    case (kind)
      0: return {`OP_B, imm11};
      1, 2: return {`OP_BEQZ, rx, imm11[7:0]};
      3, 4: return {`OP_BNEZ, rx, imm11[7:0]};
      5, 6: return {`OP_BTEQZ_GROUP, `FUNCT_BTEQZ, imm11[7:0]};
      default: return {`OP_LOGIC_JUMP, rx, `FUNCT_JR};
    endcase
  endfunction

  // New instruction with fresh data and no hazards
  task automatic driveCycle(input logic [15:0] word);
    @(negedge clk);
    inst         = word;
    instAddr     = 16'($random(seed));
    reg1Data     = 16'($random(seed));
    reg2Data     = 16'($random(seed));
    exWriteData  = 16'($random(seed));
    memWriteData = 16'($random(seed));
    exWriteEn    = 1'b0;
    exWriteAddr  = 4'd0;
    exAluOp      = `ALU_NOP;
    memWriteEn   = 1'b0;
    memWriteAddr = 4'd0;
    inDelaySlot  = 1'b0;
  endtask

  initial begin
    logic [`REG_ADDR_WIDTH-1:0] target;
    clk          = 1'b0;
    rstN         = 1'b0;
    inst         = {`OP_NOP, 11'd0};
    instAddr     = '0;
    reg1Data     = '0;
    reg2Data     = '0;
    inDelaySlot  = 1'b0;
    exWriteEn    = 1'b0;
    exWriteAddr  = '0;
    exWriteData  = '0;
    exAluOp      = `ALU_NOP;
    memWriteEn   = 1'b0;
    memWriteAddr = '0;
    memWriteData = '0;
    repeat (3) @(negedge clk);
    rstN = 1'b1;

    for (int rep = 0; rep < 8; rep++) begin
      for (int kind = 0; kind < 10; kind++) begin
        driveCycle(aluWord(kind, 3'($random(seed)), 3'($random(seed)),
                           3'($random(seed)), 8'($random(seed))));
      end
    end

    // Unlisted three-register function code decodes to nothing
    driveCycle({`OP_TRINARY, 9'($random(seed)), 2'b00});

    // ADDU r3, r5 with bypass sources aimed at one port
    for (int port = 1; port <= 2; port++) begin
      for (int mode = 0; mode < 4; mode++) begin
        driveCycle(aluWord(0, 3'd3, 3'd5, 3'd1, 8'd0));
        target       = (port == 1) ? 4'd3 : 4'd5;
        exWriteEn    = (mode == 0) || (mode == 3);
        exWriteAddr  = (mode == 3) ? 4'd7 : target;
        memWriteEn   = (mode != 2);
        memWriteAddr = exWriteAddr;
      end
    end

    // Load in execute with a hit on each port, a miss, a disabled port and no reads
    for (int k = 0; k < 5; k++) begin
      driveCycle(aluWord((k == 3) ? 5 : (k == 4) ? 9 : 0, 3'd3, 3'd5, 3'd1, 8'h12));
      exWriteEn   = 1'b1;
      exAluOp     = `ALU_LW;
      exWriteAddr = (k == 1 || k == 3) ? 4'd5 : (k == 2) ? 4'd6 : 4'd3;
    end

    for (int k = 0; k < 16; k++) begin
      driveCycle({(k % 2 == 0) ? `OP_LW : `OP_SW, 11'($random(seed))});
    end

    for (int slot = 0; slot < 2; slot++) begin
      for (int kind = 0; kind < 8; kind++) begin
        driveCycle(branchWord(kind, 3'($random(seed)), 11'($random(seed))));
        inDelaySlot = (slot == 1);
        if (kind == 1 || kind == 3 || kind == 5) begin
          reg1Data = 16'd0;
        end else if (kind == 2) begin
          // Zero arrives from memory while the register file is stale
          reg1Data     = reg1Data | 16'd1;
          memWriteEn   = 1'b1;
          memWriteAddr = {1'b0, inst.rrr.rx};
          memWriteData = 16'd0;
        end else if (kind == 6) begin
          exWriteEn   = 1'b1;
          exWriteAddr = `REG_T;
          exWriteData = exWriteData | 16'h8000;
        end else begin
          reg1Data = reg1Data | 16'd1;
        end
      end
    end

    @(negedge clk);
    $display("Run complete after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: idStage.f
+incdir+source
source/idPkg.sv
source/readPortIf.sv
source/operandForward.sv
source/decodeControl.sv
source/branchResolve.sv
source/idStage.sv
testbench/idStageTb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode-stage testbench, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir run.log
{ verilator --binary --assert -j 0 --top-module idStageTb -o idStageSim -f idStage.f &&
  ./obj_dir/idStageSim; } 2>&1 | tee run.log
grep -q "^Regression passed$" run.log && exit 0 || exit 1
